/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" \
	&& verilator --binary -f src.f --top-module tb_fgen -Mdir obj_dir -o tb_fgen \
	&& ./obj_dir/tb_fgen \
	|| exit 1

/* src.f */
src/fgen_pkg.sv
src/fgen_ctrl_fsm.sv
src/fgen_wave_table.sv
src/fgen_shaper.sv
src/fgen_top.sv
test/tb_fgen.sv

/* src/fgen_ctrl_fsm.sv */
`default_nettype none

// Three-state Moore controller of the waveform generator.
// It sits in idle until it is asked to configure or to run.
// A configure request always wins over the run enable.
// The run enable is active low, so a high level stops generation.
module fgen_ctrl_fsm (
	input  logic clk,
	input  logic rst,
	input  logic enh_conf_i,
	input  logic en_low_i,
	output logic config_en_o,
	output logic gen_en_o
);

	// The state encoding is private to this controller.
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_CONFIG = 2'd1,
		ST_GEN    = 2'd2
	} state_t;

	state_t state_q;
	state_t state_d;

	// Next-state logic.
	// The three states share the same two exits, so every state
	// goes to configure on a request and to generate when enabled.
	// Only the fall-back differs, which is idle or stay.
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (enh_conf_i) begin
					state_d = ST_CONFIG;
				end else if (!en_low_i) begin
					state_d = ST_GEN;
				end
			end
			ST_CONFIG: begin
				// Leaving configure goes straight to generate if enabled.
				if (enh_conf_i) begin
					state_d = ST_CONFIG;
				end else if (!en_low_i) begin
					state_d = ST_GEN;
				end else begin
					state_d = ST_IDLE;
				end
			end
			ST_GEN: begin
				// A new configure request interrupts a running waveform.
				if (enh_conf_i) begin
					state_d = ST_CONFIG;
				end else if (en_low_i) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				// The spare encoding falls back to idle.
				state_d = ST_IDLE;
			end
		endcase
	end

	// State register.
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// The enables are decoded from the state register alone.
	// They follow the new state in the cycle after each edge
	// and they are low while the controller is idle after reset.
	assign config_en_o = (state_q == ST_CONFIG);
	assign gen_en_o    = (state_q == ST_GEN);

endmodule

`default_nettype wire

/* src/fgen_pkg.sv */
`default_nettype none

// Shared widths, constants and types of the waveform generator.
// Every RTL file of the generator takes its definitions from here.
package fgen_pkg;

	// Width of one signed sample, and of the generator output.
	localparam int DATA_WIDTH = 16;

	// The amplitude is a signed Q1.7 value.
	// A code of 127 is just below unity and -128 is exactly minus one.
	localparam int AMP_WIDTH = 8;
	localparam int AMP_FRAC  = 7;

	// The phase address walks through a table of 256 points.
	localparam int LUT_ADDR  = 8;
	localparam int LUT_DEPTH = 256;

	// Cosine leads sine by a quarter of the table.
	localparam int QUARTER = 64;

	// All four waveforms stay inside plus and minus PEAK.
	// Scaling by a Q1.7 amplitude therefore always fits the sample width.
	localparam int PEAK = 32767;

	// Slope of the triangle per address step.
	// Half a period of 128 steps spans 65024, which keeps it inside PEAK.
	localparam int TRI_STEP = 512;

	// Used only when the sine table is built.
	localparam real PI = 3.14159265358979323846;

	typedef logic signed [DATA_WIDTH-1:0] sample_t;
	typedef logic signed [AMP_WIDTH-1:0]  amp_t;
	typedef logic        [LUT_ADDR-1:0]   addr_t;

	// Waveform selection, captured in the configure state.
	typedef enum logic [1:0] {
		WAVE_SINE     = 2'd0,
		WAVE_COSINE   = 2'd1,
		WAVE_TRIANGLE = 2'd2,
		WAVE_SQUARE   = 2'd3
	} wave_sel_t;

endpackage

`default_nettype wire

/* src/fgen_shaper.sv */
`default_nettype none

// Output stage of the generator.
// It holds the configured amplitude and waveform selection,
// picks one of the four samples and scales it by the amplitude.
// Each valid sample leaves as one registered word with a write strobe.
module fgen_shaper (
	input  logic                clk,
	input  logic                rst,
	input  logic                config_en_i,
	input  fgen_pkg::amp_t      amp_i,
	input  fgen_pkg::wave_sel_t sel_i,
	input  fgen_pkg::sample_t   sine_i,
	input  fgen_pkg::sample_t   cosine_i,
	input  fgen_pkg::sample_t   triangle_i,
	input  fgen_pkg::sample_t   square_i,
	input  logic                sample_valid_i,
	output fgen_pkg::sample_t   data_o,
	output logic                wr_en_o
);

	import fgen_pkg::*;

	amp_t      amp_q;
	wave_sel_t sel_q;
	sample_t   sel_sample;

	// Full signed product of a sample and a Q1.7 amplitude.
	logic signed [DATA_WIDTH+AMP_WIDTH-1:0] product;

	// Configuration registers.
	// They load only in the configure state and hold through generate,
	// so later changes on the inputs do not reach the output.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q <= '0;
			sel_q <= WAVE_SINE;
		end else if (config_en_i) begin
			amp_q <= amp_i;
			sel_q <= sel_i;
		end
	end

	// Waveform select.
	always_comb begin
		case (sel_q)
			WAVE_SINE:     sel_sample = sine_i;
			WAVE_COSINE:   sel_sample = cosine_i;
			WAVE_TRIANGLE: sel_sample = triangle_i;
			WAVE_SQUARE:   sel_sample = square_i;
			default:       sel_sample = sine_i;
		endcase
	end

	// Both operands are signed, so they are sign-extended to the product width.
	assign product = sel_sample * amp_q;

	// Output register.
	// Taking the bits above the fraction is the arithmetic shift by AMP_FRAC.
	// Since every sample stays within PEAK, the kept bits cannot overflow.
	// Between samples the last value stays on data_o.
	always_ff @(posedge clk) begin
		if (rst) begin
			data_o  <= '0;
			wr_en_o <= 1'b0;
		end else begin
			wr_en_o <= sample_valid_i;
			if (sample_valid_i) begin
				data_o <= product[AMP_FRAC +: DATA_WIDTH];
			end
		end
	end

endmodule

`default_nettype wire

/* src/fgen_top.sv */
`default_nettype none

// Top level of the waveform generator.
// The controller decides between configure and generate,
// the wave table turns the phase address into samples,
// and the shaper scales the selected sample and writes it out.
// A generate cycle at the controller shows up as a write two cycles later.
module fgen_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                enh_conf_i,
	input  logic                en_low_i,
	input  fgen_pkg::amp_t      amp_i,
	input  fgen_pkg::wave_sel_t sel_i,
	output fgen_pkg::sample_t   data_o,
	output logic                wr_en_o
);

	import fgen_pkg::*;

	// Enables from the controller.
	logic config_en;
	logic gen_en;

	// Registered samples from the wave table.
	sample_t sine;
	sample_t cosine;
	sample_t triangle;
	sample_t square;
	logic    sample_valid;

	fgen_ctrl_fsm i_fgen_ctrl_fsm (
		.clk         (clk),
		.rst         (rst),
		.enh_conf_i  (enh_conf_i),
		.en_low_i    (en_low_i),
		.config_en_o (config_en),
		.gen_en_o    (gen_en)
	);

	// First pipeline stage, from address to samples.
	fgen_wave_table i_fgen_wave_table (
		.clk            (clk),
		.rst            (rst),
		.gen_en_i       (gen_en),
		.sine_o         (sine),
		.cosine_o       (cosine),
		.triangle_o     (triangle),
		.square_o       (square),
		.sample_valid_o (sample_valid)
	);

	// Second pipeline stage, from samples to the written word.
	// Configure and generate never overlap, so samples in flight
	// are always scaled with a stable configuration.
	fgen_shaper i_fgen_shaper (
		.clk            (clk),
		.rst            (rst),
		.config_en_i    (config_en),
		.amp_i          (amp_i),
		.sel_i          (sel_i),
		.sine_i         (sine),
		.cosine_i       (cosine),
		.triangle_i     (triangle),
		.square_i       (square),
		.sample_valid_i (sample_valid),
		.data_o         (data_o),
		.wr_en_o        (wr_en_o)
	);

endmodule

`default_nettype wire

/* src/fgen_wave_table.sv */
`default_nettype none

// Phase address counter and waveform lookup.
// In each generate cycle the current address is turned into four samples,
// which are registered together with a valid flag.
module fgen_wave_table (
	input  logic             clk,
	input  logic             rst,
	input  logic             gen_en_i,
	output fgen_pkg::sample_t sine_o,
	output fgen_pkg::sample_t cosine_o,
	output fgen_pkg::sample_t triangle_o,
	output fgen_pkg::sample_t square_o,
	output logic             sample_valid_o
);

	import fgen_pkg::*;

	// One period of the sine, PEAK times sin(2 pi a / 256), rounded.
	sample_t sine_rom [LUT_DEPTH];

	addr_t   addr_q;
	addr_t   cos_addr;
	int      tri_val;
	sample_t square_val;

	// Computes one table point.
	// The int cast of a real rounds to the nearest integer.
	function automatic sample_t sine_point(input int idx);
		real phase;
		phase = 2.0 * PI * real'(idx) / real'(LUT_DEPTH);
		return sample_t'(int'(real'(PEAK) * $sin(phase)));
	endfunction

	// The table is constant and is built once, before the first clock.
	initial begin
		for (int i = 0; i < LUT_DEPTH; i++) begin
			sine_rom[i] = sine_point(i);
		end
	end

	// The cosine read port looks a quarter period ahead.
	// The 8-bit add wraps around the end of the table by itself.
	assign cos_addr = addr_q + addr_t'(QUARTER);

	// Triangle from the address.
	// It rises from -PEAK in the first half and falls from +PEAK in the second.
	always_comb begin
		if (addr_q[LUT_ADDR-1] == 1'b0) begin
			tri_val = -PEAK + TRI_STEP * int'(addr_q);
		end else begin
			tri_val = PEAK - TRI_STEP * (int'(addr_q) - LUT_DEPTH / 2);
		end
	end

	// Square is high for the first half of the period, low for the second.
	assign square_val = addr_q[LUT_ADDR-1] ? sample_t'(-PEAK) : sample_t'(PEAK);

	// Address counter and valid flag.
	// Outside generate the address is held at 0,
	// so every run starts at the top of the table.
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q         <= '0;
			sample_valid_o <= 1'b0;
		end else if (gen_en_i) begin
			addr_q         <= addr_q + addr_t'(1);
			sample_valid_o <= 1'b1;
		end else begin
			addr_q         <= '0;
			sample_valid_o <= 1'b0;
		end
	end

	// Sample registers.
	// They are only read while the valid flag is set.
	always_ff @(posedge clk) begin
		if (gen_en_i) begin
			sine_o     <= sine_rom[addr_q];
			cosine_o   <= sine_rom[cos_addr];
			triangle_o <= sample_t'(tri_val);
			square_o   <= square_val;
		end
	end

endmodule

`default_nettype wire

/* test/tb_fgen.sv */
`default_nettype none

// Testbench of the waveform generator.
// A model of the controller and the table runs beside the DUT on every rising edge.
// Each model generate cycle queues one expected word, and every write of the DUT
// takes the oldest word from the queue for comparison.
module tb_fgen;

	import fgen_pkg::*;

	// Model controller states.
	typedef enum {M_IDLE, M_CONF, M_GEN} mstate_t;

	logic      clk;
	logic      rst;
	logic      enh_conf_i;
	logic      en_low_i;
	amp_t      amp_i;
	wave_sel_t sel_i;
	sample_t   data_o;
	logic      wr_en_o;

	// Model state, expected words and counters.
	mstate_t m_state;
	int      m_amp;
	int      m_sel;
	int      m_addr;
	int      exp_q[$];
	int      write_count;
	string   test_name;

	// Expected write strobes.
	// A generate cycle at edge E is written out after E+1 and seen at E+2.
	logic [1:0] m_wr_pipe;

	fgen_top i_fgen_top (
		.clk        (clk),
		.rst        (rst),
		.enh_conf_i (enh_conf_i),
		.en_low_i   (en_low_i),
		.amp_i      (amp_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.wr_en_o    (wr_en_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Compares one value and stops the run on a mismatch.
	task automatic check_equal(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	// Sine point PEAK * sin(2 pi a / 256), rounded half away from zero.
	function automatic int sine_ref(input int a);
		real x;
		x = real'(PEAK) * $sin(2.0 * PI * real'(a) / real'(LUT_DEPTH));
		if (x >= 0.0) begin
			return $rtoi(x + 0.5);
		end
		return -$rtoi(0.5 - x);
	endfunction

	// Unscaled waveform at address a.
	function automatic int wave_ref(input int sel, input int a);
		int v;
		case (sel)
			0: v = sine_ref(a);
			1: v = sine_ref((a + QUARTER) % LUT_DEPTH);
			2: v = (a < 128) ? -PEAK + TRI_STEP * a : PEAK - TRI_STEP * (a - 128);
			default: v = (a < 128) ? PEAK : -PEAK;
		endcase
		return v;
	endfunction

	// All three transition tables reduce to the same rule.
	// A request wins, a low enable runs, and anything else rests in idle.
	function automatic mstate_t next_state(input logic conf, input logic en_low);
		if (conf) begin
			return M_CONF;
		end
		return en_low ? M_IDLE : M_GEN;
	endfunction

	// Scoreboard first, on the outputs from before this edge, then the model step.
	always @(posedge clk) begin
		if (rst) begin
			m_state   = M_IDLE;
			m_amp     = 0;
			m_sel     = 0;
			m_addr    = 0;
			m_wr_pipe = 2'b00;
		end else begin
			if (wr_en_o && exp_q.size() == 0) begin
				$display("A write of %0d came out with no sample pending", data_o);
				$display("TB FAILED");
				$fatal(1, "Unexpected write in %s", test_name);
			end
			// The strobe must follow each generate cycle after exactly two edges.
			check_equal({test_name, " wr_en"}, int'(m_wr_pipe[1]), int'(wr_en_o));
			if (wr_en_o) begin
				write_count++;
				check_equal(test_name, exp_q.pop_front(), int'(data_o));
			end
			m_wr_pipe = {m_wr_pipe[0], m_state == M_GEN};
			if (m_state == M_GEN) begin
				exp_q.push_back((wave_ref(m_sel, m_addr) * m_amp) >>> AMP_FRAC);
				m_addr = (m_addr + 1) % LUT_DEPTH;
			end else begin
				m_addr = 0;
			end
			if (m_state == M_CONF) begin
				m_amp = int'(amp_i);
				m_sel = int'(sel_i);
			end
			m_state = next_state(enh_conf_i, en_low_i);
		end
	end

	task automatic scramble_config();
		amp_i = amp_t'($urandom_range(0, 255));
		sel_i = wave_sel_t'($urandom_range(0, 3));
	endtask

	// Holds the request for one cycle and keeps the values through the capture edge.
	task automatic configure(input amp_t amp, input wave_sel_t sel);
		enh_conf_i = 1'b1;
		amp_i      = amp;
		sel_i      = sel;
		@(negedge clk);
		enh_conf_i = 1'b0;
		@(negedge clk);
	endtask

	task automatic run_cycles(input int n, input logic run, input logic scramble);
		enh_conf_i = 1'b0;
		en_low_i   = !run;
		repeat (n) begin
			if (scramble) begin
				scramble_config();
			end
			@(negedge clk);
		end
	endtask

	// Stops generation and waits until every queued word has been written.
	task automatic drain();
		int waited = 0;
		enh_conf_i = 1'b0;
		en_low_i   = 1'b1;
		while (!(exp_q.size() == 0 && m_state == M_IDLE && !wr_en_o)) begin
			@(negedge clk);
			waited++;
			if (waited > 50) begin
				$display("Writes are missing, %0d samples never came out", exp_q.size());
				$display("TB FAILED");
				$fatal(1, "Drain timeout in %s", test_name);
			end
		end
	endtask

	initial begin
		int  w0;
		logic run_mode;
		void'($urandom(59268));
		rst         = 1'b1;
		enh_conf_i  = 1'b0;
		en_low_i    = 1'b1;
		amp_i       = '0;
		sel_i       = WAVE_SINE;
		write_count = 0;
		test_name   = "reset_idle";
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// Idle after reset writes nothing and the output stays 0.
		repeat (20) begin
			check_equal("reset_idle wr_en", 0, int'(wr_en_o));
			check_equal("reset_idle data", 0, int'(data_o));
			@(negedge clk);
		end

		// Every waveform with a positive and a negative amplitude.
		test_name = "waveforms";
		for (int s = 0; s < 4; s++) begin
			configure(amp_t'($urandom_range(1, 127)), wave_sel_t'(s));
			run_cycles(40, 1'b1, 1'b0);
			drain();
			configure(amp_t'(-int'($urandom_range(1, 128))), wave_sel_t'(s));
			run_cycles(40, 1'b1, 1'b0);
			drain();
		end

		// One long run crosses the end of the table.
		test_name = "address_wrap";
		configure(amp_t'(8'sd127), WAVE_TRIANGLE);
		w0 = write_count;
		run_cycles(300, 1'b1, 1'b0);
		drain();
		check_equal("address_wrap writes", 300, write_count - w0);

		// Inputs move outside configure, and a run is reconfigured on the fly.
		test_name = "config_hold";
		configure(amp_t'($urandom_range(1, 127)), WAVE_SINE);
		run_cycles(5, 1'b0, 1'b1);
		run_cycles(30, 1'b1, 1'b1);
		configure(amp_t'(-int'($urandom_range(1, 128))), WAVE_COSINE);
		run_cycles(30, 1'b1, 1'b1);
		drain();

		// Random control with long generate runs.
		test_name = "random_control";
		run_mode  = 1'b1;
		repeat (2000) begin
			if ($urandom_range(0, 39) == 0) begin
				run_mode = !run_mode;
			end
			enh_conf_i = ($urandom_range(0, 24) == 0);
			en_low_i   = run_mode ? ($urandom_range(0, 49) == 0) : ($urandom_range(0, 2) != 0);
			scramble_config();
			@(negedge clk);
		end
		drain();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
